/* cpu16.f */
verilog/cpu16Pkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/cpu16.sv
verification/tbClock.sv
verification/cpu16Tb.sv

/* verification/cpu16Tb.sv */
`default_nettype none

module cpu16Tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int imemWords = 512;
  localparam int dmemWords = 32768;
  localparam int clkPeriod = 10;
  localparam cpu16Pkg::wordT startAddr = 16'h0000;

  logic clk;
  logic rstN;
  cpu16Pkg::wordT imemData;
  cpu16Pkg::wordT dmemRdData;
  cpu16Pkg::wordT imemAddr;
  cpu16Pkg::wordT dmemAddr;
  cpu16Pkg::wordT dmemWrData;
  logic dmemWrEn;
  logic dmemRdEn;
  cpu16Pkg::wordT pc;
  logic hlt;

  cpu16Pkg::wordT imem [imemWords];
  cpu16Pkg::wordT dmem [dmemWords];
  cpu16Pkg::wordT refMem [dmemWords];   // the model's own copy of data memory
  cpu16Pkg::wordT expAddrQ [$];
  cpu16Pkg::wordT expDataQ [$];
  cpu16Pkg::wordT haltPc;
  integer seed = 58217;
  int progLen = 0;
  int storeIdx = 0;
  int expLoads = 0;
  int loadCount = 0;
  int checkCount = 0;
  int valueErrors = 0;
  int otherErrors = 0;
  bit programReady = 1'b0;

  tbClock u_clock (.clk(clk), .rstN(rstN));

  cpu16 #(.resetAddr(startAddr)) u_dut (
    .clk(clk), .rstN(rstN), .imemData(imemData), .dmemRdData(dmemRdData),
    .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
    .dmemWrEn(dmemWrEn), .dmemRdEn(dmemRdEn), .pc(pc), .hlt(hlt)
  );

  // every data word starts with a value tied to its full address
  function automatic cpu16Pkg::wordT fillWord(int idx);
    return cpu16Pkg::wordT'(idx * 40503) ^ 16'h5A5A;
  endfunction

  function automatic cpu16Pkg::wordT imemWord(cpu16Pkg::wordT addr);
    if (addr[15:1] < imemWords) return imem[addr[15:1]];
    return '0;   // past the program or an unknown address during reset
  endfunction

  function automatic cpu16Pkg::wordT encodeInst(cpu16Pkg::opcodeT op, int a, int b, int c);
    return {op, a[3:0], b[3:0], c[3:0]};
  endfunction

  task automatic emit(cpu16Pkg::wordT inst);
    imem[progLen] = inst;
    progLen++;
  endtask

  task automatic seedReg(int r, cpu16Pkg::wordT value);
    emit(encodeInst(cpu16Pkg::opLlb, r, value[7:4], value[3:0]));
    emit(encodeInst(cpu16Pkg::opLhb, r, value[15:12], value[11:8]));
  endtask

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    checkCount++;
    if (actual !== expected) begin
      valueErrors++;
      $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  task automatic buildProgram();
    cpu16Pkg::opcodeT aluCode;
    int op;
    int rd;
    for (int i = 0; i < imemWords; i++) begin
      imem[i] = '0;
    end
    seedReg(15, 16'h0200);   // store base
    for (int r = 1; r <= 13; r++) begin
      seedReg(r, cpu16Pkg::wordT'($random(seed)));
    end
    // random ALU ops with each result stored right after
    for (int i = 0; i < 16; i++) begin
      op = $unsigned($random(seed)) % 3;
      rd = 1 + $unsigned($random(seed)) % 13;
      case (op)
        0: aluCode = cpu16Pkg::opAdd;
        1: aluCode = cpu16Pkg::opSub;
        default: aluCode = cpu16Pkg::opXor;
      endcase
      emit(encodeInst(aluCode, rd, $unsigned($random(seed)) % 14, $unsigned($random(seed)) % 14));
      emit(encodeInst(cpu16Pkg::opSw, rd, 15, $unsigned($random(seed)) % 16));
    end
    // dependencies one, two and three apart
    emit(encodeInst(cpu16Pkg::opAdd, 1, 2, 3));
    emit(encodeInst(cpu16Pkg::opSub, 4, 1, 2));    // r1 out of EX/MEM
    emit(encodeInst(cpu16Pkg::opXor, 5, 4, 1));    // r4 out of EX/MEM, r1 out of MEM/WB
    emit(encodeInst(cpu16Pkg::opSw, 5, 15, 0));    // store data forwarded from EX/MEM
    emit(encodeInst(cpu16Pkg::opAdd, 6, 5, 4));
    emit(encodeInst(cpu16Pkg::opAdd, 7, 1, 1));
    emit(encodeInst(cpu16Pkg::opSw, 6, 15, 1));    // store data forwarded from MEM/WB
    emit(encodeInst(cpu16Pkg::opAdd, 14, 15, 0));
    emit(encodeInst(cpu16Pkg::opSw, 7, 14, 2));    // the base itself comes from EX/MEM
    emit(encodeInst(cpu16Pkg::opAdd, 11, 1, 2));
    emit(encodeInst(cpu16Pkg::opAdd, 0, 0, 0));
    emit(encodeInst(cpu16Pkg::opAdd, 0, 0, 0));
    emit(encodeInst(cpu16Pkg::opSw, 11, 14, 3));   // read through the register file bypass
    emit(encodeInst(cpu16Pkg::opXor, 12, 11, 11));
    emit(encodeInst(cpu16Pkg::opSub, 13, 12, 7));
    emit(encodeInst(cpu16Pkg::opSw, 13, 14, 4));
    // loads used at once
    emit(encodeInst(cpu16Pkg::opLw, 1, 15, 0));
    emit(encodeInst(cpu16Pkg::opAdd, 2, 1, 3));    // load-use stall
    emit(encodeInst(cpu16Pkg::opSw, 2, 15, 4));
    emit(encodeInst(cpu16Pkg::opLw, 3, 15, 14));
    emit(encodeInst(cpu16Pkg::opSw, 3, 15, 5));    // stall on the store data
    emit(encodeInst(cpu16Pkg::opLw, 4, 15, 8));
    emit(encodeInst(cpu16Pkg::opLw, 5, 4, 3));     // loaded value used as the base
    emit(encodeInst(cpu16Pkg::opXor, 6, 5, 4));
    emit(encodeInst(cpu16Pkg::opSw, 6, 15, 6));
    emit(encodeInst(cpu16Pkg::opLw, 7, 15, 1));
    emit(encodeInst(cpu16Pkg::opAdd, 0, 0, 0));
    emit(encodeInst(cpu16Pkg::opSw, 7, 15, 7));
    // byte merges into live values and writes that r0 ignores
    emit(encodeInst(cpu16Pkg::opLlb, 8, 'hA, 'h5));
    emit(encodeInst(cpu16Pkg::opSw, 8, 15, 9));
    emit(encodeInst(cpu16Pkg::opLhb, 8, 'h3, 'hC));
    emit(encodeInst(cpu16Pkg::opSw, 8, 15, 10));
    emit(encodeInst(cpu16Pkg::opAdd, 9, 1, 2));
    emit(encodeInst(cpu16Pkg::opLhb, 9, 'hE, 'h7));
    emit(encodeInst(cpu16Pkg::opSw, 9, 15, 11));
    emit(encodeInst(cpu16Pkg::opLlb, 0, 'h7, 'h7));
    emit(encodeInst(cpu16Pkg::opAdd, 0, 1, 2));
    emit(encodeInst(cpu16Pkg::opAdd, 10, 0, 1));   // r0 must still read as zero here
    emit(encodeInst(cpu16Pkg::opSw, 0, 15, 12));
    emit(encodeInst(cpu16Pkg::opSw, 10, 15, 13));
    emit(encodeInst(cpu16Pkg::opLw, 0, 15, 0));
    emit(encodeInst(cpu16Pkg::opSub, 11, 1, 0));
    emit(encodeInst(cpu16Pkg::opSw, 11, 15, 14));
    emit(encodeInst(cpu16Pkg::opHlt, 0, 0, 0));
    emit(encodeInst(cpu16Pkg::opSw, 1, 15, 0));    // never fetched once HLT is seen
    emit(encodeInst(cpu16Pkg::opSw, 2, 15, 1));
  endtask

  // runs the program in order by the ISA rules, lists its stores and returns the halt PC
  function automatic cpu16Pkg::wordT isaRun();
    cpu16Pkg::wordT regs [16];
    cpu16Pkg::wordT inst;
    cpu16Pkg::wordT pcRef;
    cpu16Pkg::wordT addr;
    cpu16Pkg::wordT value;
    logic wr;
    int rd;
    int rs;
    int rt;
    for (int r = 0; r < 16; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < dmemWords; i++) begin
      refMem[i] = fillWord(i);
    end
    expAddrQ.delete();
    expDataQ.delete();
    expLoads = 0;
    pcRef = startAddr;
    for (int step = 0; step < imemWords; step++) begin
      inst = imemWord(pcRef);
      rd = inst[11:8];
      rs = inst[7:4];
      rt = inst[3:0];
      addr = {regs[rs][15:1], 1'b0} + {{11{inst[3]}}, inst[3:0], 1'b0};
      wr = 1'b1;
      value = '0;
      case (inst[15:12])
        cpu16Pkg::opAdd: value = regs[rs] + regs[rt];
        cpu16Pkg::opSub: value = regs[rs] - regs[rt];
        cpu16Pkg::opXor: value = regs[rs] ^ regs[rt];
        cpu16Pkg::opLw: begin
          value = refMem[addr[15:1]];
          expLoads++;
        end
        cpu16Pkg::opSw: begin
          wr = 1'b0;
          refMem[addr[15:1]] = regs[rd];
          expAddrQ.push_back(addr);
          expDataQ.push_back(regs[rd]);
        end
        cpu16Pkg::opLlb: value = {regs[rd][15:8], inst[7:0]};
        cpu16Pkg::opLhb: value = {inst[7:0], regs[rd][7:0]};
        cpu16Pkg::opHlt: return pcRef + 16'd2;
        default: wr = 1'b0;
      endcase
      if (wr && rd != 0) begin
        regs[rd] = value;
      end
      pcRef = pcRef + 16'd2;
    end
    return pcRef;
  endfunction

  // inputs change 1 ns after the rising edge and follow the addresses as combinational reads
  always @(posedge clk) begin
    #1;
    imemData   = imemWord(imemAddr);
    dmemRdData = (dmemRdEn === 1'b1) ? dmem[dmemAddr[15:1]] : '0;
  end

  always @(posedge clk) begin
    if (rstN && dmemWrEn === 1'b1) begin
      dmem[dmemAddr[15:1]] = dmemWrData;
    end
  end

  // each store is matched against the next one the model expects
  always @(negedge clk) begin
    if (rstN && dmemRdEn === 1'b1) begin
      loadCount++;
    end
    if (rstN && dmemWrEn === 1'b1) begin
      if (storeIdx < expAddrQ.size()) begin
        checkEq(dmemAddr, expAddrQ[storeIdx], "store address");
        checkEq(dmemWrData, expDataQ[storeIdx], "store data");
      end else begin
        otherErrors++;
        $display("Unexpected store to 0x%04h at %0d ns after all expected stores",
                 dmemAddr, $time);
      end
      storeIdx++;
    end
  end

  initial begin
    imemData   = '0;
    dmemRdData = '0;
    buildProgram();
    for (int i = 0; i < dmemWords; i++) begin
      dmem[i] = fillWord(i);
    end
    haltPc = isaRun();
    programReady = 1'b1;
    wait (rstN === 1'b1);
    while (hlt !== 1'b1) begin
      @(negedge clk);
    end
    // keep running past the halt to catch stray stores or a moving PC
    repeat (6) begin
      @(negedge clk);
      checkEq(hlt, 1'b1, "hlt");
      checkEq(pc, haltPc, "pc after halt");
    end
    checkEq(storeIdx, expAddrQ.size(), "store count");
    checkEq(loadCount, expLoads, "load count");
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checkCount, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // the time limit grows with the program length
  initial begin
    wait (programReady);
    #((2 * progLen + 20) * clkPeriod);
    $display("Timed out: the CPU did not halt within %0d cycles", 2 * progLen + 20);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tbClock.sv */
`default_nettype none

module tbClock (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns period
  end

  // reset is released 1 ns after the third rising edge
  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/cpu16.sv */
`default_nettype none

module cpu16 #(
  parameter cpu16Pkg::wordT resetAddr = '0
) (
  input  wire                  clk,
  input  wire                  rstN,
  input  wire cpu16Pkg::wordT  imemData,
  input  wire cpu16Pkg::wordT  dmemRdData,
  output cpu16Pkg::wordT       imemAddr,
  output cpu16Pkg::wordT       dmemAddr,
  output cpu16Pkg::wordT       dmemWrData,
  output logic                 dmemWrEn,
  output logic                 dmemRdEn,
  output cpu16Pkg::wordT       pc,
  output logic                 hlt
);

  // IF/ID
  cpu16Pkg::wordT ifInst;
  cpu16Pkg::wordT ifPcInc;
  logic stall;

  // ID/EX
  cpu16Pkg::regAddrT exRs;
  cpu16Pkg::regAddrT exRt;
  cpu16Pkg::regAddrT exRd;
  cpu16Pkg::wordT exSrc1;
  cpu16Pkg::wordT exSrc2;
  cpu16Pkg::aluOpT exAluOp;
  cpu16Pkg::wordT exImm;
  cpu16Pkg::opcodeT exOpcode;
  logic exWriteReg;
  logic exMemRead;
  logic exMemWrite;

  // EX/MEM
  cpu16Pkg::wordT memResult;
  cpu16Pkg::wordT memStoreData;
  cpu16Pkg::regAddrT memRd;
  logic memWriteReg;
  logic memRead;
  logic memWrite;
  logic memHalt;

  // MEM/WB, feeding both the register file and forwarding
  logic wbEn;
  cpu16Pkg::regAddrT wbReg;
  cpu16Pkg::wordT wbData;

  assign pc = imemAddr;

  fetchStage #(.resetAddr(resetAddr)) u_fetch (
    .clk(clk), .rstN(rstN), .stall(stall), .imemData(imemData),
    .imemAddr(imemAddr), .ifInst(ifInst), .ifPcInc(ifPcInc)
  );

  decodeStage u_decode (
    .clk(clk), .rstN(rstN), .ifInst(ifInst), .ifPcInc(ifPcInc), .stall(stall),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
    .exRs(exRs), .exRt(exRt), .exRd(exRd), .exSrc1(exSrc1), .exSrc2(exSrc2),
    .exAluOp(exAluOp), .exImm(exImm), .exOpcode(exOpcode),
    .exWriteReg(exWriteReg), .exMemRead(exMemRead), .exMemWrite(exMemWrite)
  );

  executeStage u_execute (
    .clk(clk), .rstN(rstN),
    .exRs(exRs), .exRt(exRt), .exRd(exRd), .exSrc1(exSrc1), .exSrc2(exSrc2),
    .exAluOp(exAluOp), .exImm(exImm), .exOpcode(exOpcode),
    .exWriteReg(exWriteReg), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
    .memResult(memResult), .memStoreData(memStoreData), .memRd(memRd),
    .memWriteReg(memWriteReg), .memRead(memRead), .memWrite(memWrite), .memHalt(memHalt)
  );

  memWbStage u_memWb (
    .clk(clk), .rstN(rstN),
    .memResult(memResult), .memStoreData(memStoreData), .memRd(memRd),
    .memWriteReg(memWriteReg), .memRead(memRead), .memWrite(memWrite), .memHalt(memHalt),
    .dmemRdData(dmemRdData), .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
    .dmemWrEn(dmemWrEn), .dmemRdEn(dmemRdEn),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .hlt(hlt)
  );

endmodule

`default_nettype wire

/* verilog/memWbStage.sv */
`default_nettype none

module memWbStage (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire cpu16Pkg::wordT     memResult,
  input  wire cpu16Pkg::wordT     memStoreData,
  input  wire cpu16Pkg::regAddrT  memRd,
  input  wire                     memWriteReg,
  input  wire                     memRead,
  input  wire                     memWrite,
  input  wire                     memHalt,
  input  wire cpu16Pkg::wordT     dmemRdData,
  output cpu16Pkg::wordT          dmemAddr,
  output cpu16Pkg::wordT          dmemWrData,
  output logic                    dmemWrEn,
  output logic                    dmemRdEn,
  output logic                    wbEn,
  output cpu16Pkg::regAddrT       wbReg,
  output cpu16Pkg::wordT          wbData,
  output logic                    hlt
);

  // the data port is combinational, so it is driven straight from EX/MEM
  assign dmemAddr   = memResult;
  assign dmemWrData = memStoreData;
  assign dmemWrEn   = memWrite;
  assign dmemRdEn   = memRead;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbEn <= 1'b0;
      hlt  <= 1'b0;
    end else begin
      wbEn <= memWriteReg;
      hlt  <= hlt | memHalt;   // sticky until the next reset
    end
  end

  always_ff @(posedge clk) begin
    wbReg  <= memRd;
    wbData <= memRead ? dmemRdData : memResult;
  end

  // decode never marks one instruction as both load and store
  noReadWrite: assert property (
    @(posedge clk) disable iff (!rstN)
    !(dmemWrEn && dmemRdEn)
  );

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`default_nettype none

module executeStage (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire cpu16Pkg::regAddrT  exRs,
  input  wire cpu16Pkg::regAddrT  exRt,
  input  wire cpu16Pkg::regAddrT  exRd,
  input  wire cpu16Pkg::wordT     exSrc1,
  input  wire cpu16Pkg::wordT     exSrc2,
  input  wire cpu16Pkg::aluOpT    exAluOp,
  input  wire cpu16Pkg::wordT     exImm,
  input  wire cpu16Pkg::opcodeT   exOpcode,
  input  wire                     exWriteReg,
  input  wire                     exMemRead,
  input  wire                     exMemWrite,
  input  wire                     wbEn,
  input  wire cpu16Pkg::regAddrT  wbReg,
  input  wire cpu16Pkg::wordT     wbData,
  output cpu16Pkg::wordT          memResult,
  output cpu16Pkg::wordT          memStoreData,
  output cpu16Pkg::regAddrT       memRd,
  output logic                    memWriteReg,
  output logic                    memRead,
  output logic                    memWrite,
  output logic                    memHalt
);

  cpu16Pkg::wordT src1;
  cpu16Pkg::wordT src2;
  cpu16Pkg::wordT aluOut;
  cpu16Pkg::wordT addr;
  cpu16Pkg::wordT result;
  logic fwd1Mem;
  logic fwd1Wb;
  logic fwd2Mem;
  logic fwd2Wb;
  logic memFwdOk;   // EX/MEM holds a non-load result for a real register

  assign memFwdOk = memWriteReg && !memRead && (memRd != '0);

  assign fwd1Mem = memFwdOk && (memRd == exRs);
  assign fwd2Mem = memFwdOk && (memRd == exRt);
  assign fwd1Wb  = wbEn && (wbReg != '0) && (wbReg == exRs);
  assign fwd2Wb  = wbEn && (wbReg != '0) && (wbReg == exRt);

  // the younger producer in EX/MEM wins over MEM/WB
  assign src1 = fwd1Mem ? memResult : fwd1Wb ? wbData : exSrc1;
  assign src2 = fwd2Mem ? memResult : fwd2Wb ? wbData : exSrc2;

  always_comb begin
    case (exAluOp)
      cpu16Pkg::aluSub: aluOut = src1 - src2;
      cpu16Pkg::aluXor: aluOut = src1 ^ src2;
      default:          aluOut = src1 + src2;   // wraps at 16 bits
    endcase
  end

  assign addr = {src1[cpu16Pkg::wordWidth-1:1], 1'b0} + exImm;   // word aligned base

  always_comb begin
    case (exOpcode)
      cpu16Pkg::opLw, cpu16Pkg::opSw: result = addr;
      cpu16Pkg::opLlb: result = {src2[15:8], exImm[7:0]};
      cpu16Pkg::opLhb: result = {exImm[7:0], src2[7:0]};
      default:         result = aluOut;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteReg <= 1'b0;
      memRead     <= 1'b0;
      memWrite    <= 1'b0;
      memHalt     <= 1'b0;
    end else begin
      memWriteReg <= exWriteReg;
      memRead     <= exMemRead;
      memWrite    <= exMemWrite;
      memHalt     <= (exOpcode == cpu16Pkg::opHlt);
    end
  end

  always_ff @(posedge clk) begin
    memResult    <= result;
    memStoreData <= src2;   // SW data after forwarding
    memRd        <= exRd;
  end

  // r0 reaches the ALU as zero whatever EX/MEM and MEM/WB are holding
  noFwdFromR0: assert property (
    @(posedge clk) disable iff (!rstN)
    !(exRs == '0 && src1 != '0) && !(exRt == '0 && src2 != '0)
  );

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`default_nettype none

module decodeStage (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire cpu16Pkg::wordT     ifInst,
  input  wire cpu16Pkg::wordT     ifPcInc,
  output logic                    stall,
  input  wire                     wbEn,
  input  wire cpu16Pkg::regAddrT  wbReg,
  input  wire cpu16Pkg::wordT     wbData,
  output cpu16Pkg::regAddrT       exRs,
  output cpu16Pkg::regAddrT       exRt,
  output cpu16Pkg::regAddrT       exRd,
  output cpu16Pkg::wordT          exSrc1,
  output cpu16Pkg::wordT          exSrc2,
  output cpu16Pkg::aluOpT         exAluOp,
  output cpu16Pkg::wordT          exImm,
  output cpu16Pkg::opcodeT        exOpcode,
  output logic                    exWriteReg,
  output logic                    exMemRead,
  output logic                    exMemWrite
);

  cpu16Pkg::opcodeT opcode;
  cpu16Pkg::regAddrT rd;
  cpu16Pkg::regAddrT rs;
  cpu16Pkg::regAddrT rt;
  cpu16Pkg::regAddrT src2Idx;
  cpu16Pkg::wordT rdData1;
  cpu16Pkg::wordT rdData2;
  cpu16Pkg::wordT imm;
  cpu16Pkg::aluOpT aluOp;
  logic [cpu16Pkg::imm4Width-1:0] imm4;
  logic [cpu16Pkg::imm8Width-1:0] imm8;
  logic writeReg;
  logic memRead;
  logic memWrite;
  logic usesRs;
  logic usesSrc2;
  logic src2FromRd;   // SW, LLB and LHB read rd through the second port

  assign opcode = cpu16Pkg::opcodeT'(ifInst[cpu16Pkg::opcodeLsb +: cpu16Pkg::opcodeWidth]);
  assign rd     = ifInst[cpu16Pkg::rdLsb +: cpu16Pkg::regAddrWidth];
  assign rs     = ifInst[cpu16Pkg::rsLsb +: cpu16Pkg::regAddrWidth];
  assign rt     = ifInst[cpu16Pkg::rtLsb +: cpu16Pkg::regAddrWidth];
  assign imm4   = ifInst[cpu16Pkg::rtLsb +: cpu16Pkg::imm4Width];
  assign imm8   = ifInst[cpu16Pkg::rtLsb +: cpu16Pkg::imm8Width];

  always_comb begin
    writeReg   = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    usesRs     = 1'b0;
    usesSrc2   = 1'b0;
    src2FromRd = 1'b0;
    aluOp      = cpu16Pkg::aluAdd;
    case (opcode)
      cpu16Pkg::opAdd, cpu16Pkg::opSub, cpu16Pkg::opXor: begin
        writeReg = 1'b1;
        usesRs   = 1'b1;
        usesSrc2 = 1'b1;
        if (opcode == cpu16Pkg::opSub) aluOp = cpu16Pkg::aluSub;
        if (opcode == cpu16Pkg::opXor) aluOp = cpu16Pkg::aluXor;
      end
      cpu16Pkg::opLw: begin
        writeReg = 1'b1;
        memRead  = 1'b1;
        usesRs   = 1'b1;
      end
      cpu16Pkg::opSw: begin
        memWrite   = 1'b1;
        usesRs     = 1'b1;
        usesSrc2   = 1'b1;
        src2FromRd = 1'b1;
      end
      cpu16Pkg::opLlb, cpu16Pkg::opLhb: begin
        writeReg   = 1'b1;
        usesSrc2   = 1'b1;
        src2FromRd = 1'b1;
      end
      default: ;   // HLT and unused codes carry no control
    endcase
  end

  assign src2Idx = src2FromRd ? rd : rt;

  // memory ops take imm4 as a signed word offset, the byte loads take imm8 as is
  assign imm = (memRead || memWrite)
             ? {{(cpu16Pkg::wordWidth - cpu16Pkg::imm4Width - 1){imm4[cpu16Pkg::imm4Width-1]}},
                imm4, 1'b0}
             : {{(cpu16Pkg::wordWidth - cpu16Pkg::imm8Width){1'b0}}, imm8};

  // load in ID/EX whose target is needed right away
  assign stall = exMemRead && (exRd != '0) &&
                 ((usesRs && exRd == rs) || (usesSrc2 && exRd == src2Idx));

  regFile u_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddr1 (rs),
    .rdAddr2 (src2Idx),
    .rdData1 (rdData1),
    .rdData2 (rdData2),
    .wrEn    (wbEn),
    .wrAddr  (wbReg),
    .wrData  (wbData)
  );

  always_ff @(posedge clk) begin
    if (!rstN || stall) begin   // a stall sends a bubble into execute
      exWriteReg <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exOpcode   <= cpu16Pkg::opAdd;
      exAluOp    <= cpu16Pkg::aluAdd;
    end else begin
      exWriteReg <= writeReg;
      exMemRead  <= memRead;
      exMemWrite <= memWrite;
      exOpcode   <= opcode;
      exAluOp    <= aluOp;
    end
  end

  always_ff @(posedge clk) begin
    exRs   <= rs;
    exRt   <= src2Idx;
    exRd   <= rd;
    exSrc1 <= rdData1;
    exSrc2 <= rdData2;
    exImm  <= imm;
  end

  // the bubble removes the load hazard, so one stall cycle is always enough
  stallOneCycle: assert property (
    @(posedge clk) disable iff (!rstN)
    stall |=> !stall
  );

  // fetch keeps IF/ID intact while decode stalls
  ifIdHeld: assert property (
    @(posedge clk) disable iff (!rstN)
    stall |=> $stable(ifInst) && $stable(ifPcInc)
  );

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire cpu16Pkg::regAddrT  rdAddr1,
  input  wire cpu16Pkg::regAddrT  rdAddr2,
  output cpu16Pkg::wordT          rdData1,
  output cpu16Pkg::wordT          rdData2,
  input  wire                     wrEn,
  input  wire cpu16Pkg::regAddrT  wrAddr,
  input  wire cpu16Pkg::wordT     wrData
);

  cpu16Pkg::wordT regs [2**cpu16Pkg::regAddrWidth];
  logic           wrLive;

  // a write to r0 is dropped here and on the bypass path
  assign wrLive = wrEn && (wrAddr != '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 2**cpu16Pkg::regAddrWidth; i++) begin
        regs[i] <= '0;   // the byte merges of LLB/LHB start from a known zero
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

  // write before read, so the value written back this cycle is seen by decode
  always_comb begin
    if (rdAddr1 == '0)                       rdData1 = '0;
    else if (wrLive && wrAddr == rdAddr1)    rdData1 = wrData;
    else                                     rdData1 = regs[rdAddr1];
  end

  always_comb begin
    if (rdAddr2 == '0)                       rdData2 = '0;
    else if (wrLive && wrAddr == rdAddr2)    rdData2 = wrData;
    else                                     rdData2 = regs[rdAddr2];
  end

endmodule

`default_nettype wire

/* verilog/fetchStage.sv */
`default_nettype none

module fetchStage #(
  parameter cpu16Pkg::wordT resetAddr = '0
) (
  input  wire                  clk,
  input  wire                  rstN,
  input  wire                  stall,
  input  wire cpu16Pkg::wordT  imemData,
  output cpu16Pkg::wordT       imemAddr,
  output cpu16Pkg::wordT       ifInst,
  output cpu16Pkg::wordT       ifPcInc
);

  cpu16Pkg::wordT pcReg;
  cpu16Pkg::wordT pcNext;
  cpu16Pkg::opcodeT fetchOp;
  logic fetchedHlt;   // HLT has been latched into IF/ID and fetch is frozen
  logic advance;

  assign imemAddr = pcReg;
  assign pcNext   = pcReg + cpu16Pkg::wordT'(2);
  assign fetchOp  = cpu16Pkg::opcodeT'(imemData[cpu16Pkg::opcodeLsb +: cpu16Pkg::opcodeWidth]);

  // the PC moves past the HLT once and then holds there
  assign advance = !stall && !fetchedHlt;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcReg      <= resetAddr;
      fetchedHlt <= 1'b0;
      ifInst     <= '0;   // IF/ID starts out holding a no-op
    end else if (advance) begin
      pcReg      <= pcNext;
      fetchedHlt <= (fetchOp == cpu16Pkg::opHlt);
      ifInst     <= imemData;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ifPcInc <= pcNext;
    end
  end

  // a load-use stall must freeze the fetch address for that cycle
  pcHoldOnStall: assert property (
    @(posedge clk) disable iff (!rstN)
    stall |=> $stable(pcReg)
  );

endmodule

`default_nettype wire

/* verilog/cpu16Pkg.sv */
`default_nettype none

package cpu16Pkg;

  localparam int wordWidth    = 16;
  localparam int regAddrWidth = 4;
  localparam int opcodeWidth  = 4;

  // bit positions of the instruction fields
  localparam int opcodeLsb = 12;
  localparam int rdLsb     = 8;
  localparam int rsLsb     = 4;
  localparam int rtLsb     = 0;   // imm4 and imm8 start here as well
  localparam int imm4Width = 4;
  localparam int imm8Width = 8;

  typedef logic [wordWidth-1:0]    wordT;
  typedef logic [regAddrWidth-1:0] regAddrT;

  typedef enum logic [opcodeWidth-1:0] {
    opAdd = 4'h0,   // 0x0000 is ADD r0 and doubles as the no-op
    opSub = 4'h1,
    opXor = 4'h2,
    opLw  = 4'h8,
    opSw  = 4'h9,
    opLlb = 4'hA,
    opLhb = 4'hB,
    opHlt = 4'hF
  } opcodeT;

  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluXor
  } aluOpT;

endpackage

`default_nettype wire
